// File: hdl/spidergon_pkg.sv
// spidergon shared definitions: port directions, port count and the routing rule

package spidergon_pkg;

	// router port names, STOP means eject at this node
	typedef enum logic [1:0]
	{
		ANTI_CLOCKWISE = 2'd0,
		CLOCKWISE      = 2'd1,
		ACROSS         = 2'd2,
		STOP           = 2'd3
	} port_dir_t;

	// link ports per node: anticlockwise, clockwise, across
	localparam int NUM_OF_PORTS = 3;

	// across-first routing on the spidergon ring
	// rel is the clockwise distance from current to dest
	function automatic port_dir_t route_dir(input int current, input int dest,
		input int num_nodes);
		int rel;
		rel = (dest - current + num_nodes) % num_nodes;
		if (rel == 0)
		begin
			return STOP;
		end
		else if (rel <= num_nodes / 4)
		begin
			return CLOCKWISE;
		end
		else if (rel >= num_nodes - num_nodes / 4)
		begin
			return ANTI_CLOCKWISE;
		end
		else
		begin
			// far half of the ring, jump across first
			return ACROSS;
		end
	endfunction

endpackage

// File: hdl/flit_injector.sv
// flit injector: captures a local send request as a single flit and holds it for the router
`timescale 1ns/1ps

module flit_injector
#(
	parameter int NODE_ID = 0,
	parameter int NUM_OF_NODES = 8,
	parameter int FLIT_DATA_WIDTH = 16,
	localparam int NODE_ID_WIDTH = $clog2(NUM_OF_NODES),
	localparam int FLIT_WIDTH = 2 * NODE_ID_WIDTH + FLIT_DATA_WIDTH
)
(
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       inject_valid,
	input  logic [NODE_ID_WIDTH-1:0]   inject_dest,
	input  logic [FLIT_DATA_WIDTH-1:0] inject_data,
	output logic                       inject_busy,
	output logic [FLIT_WIDTH-1:0]      local_flit,
	output logic                       local_valid,
	input  logic                       local_take
);

	logic                  busy;
	logic [FLIT_WIDTH-1:0] flit_q;

	// busy rises on capture and falls when the router takes the flit
	// a request that arrives while busy is dropped
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
		end
		else if (busy)
		begin
			if (local_take)
				busy <= 1'b0;
		end
		else if (inject_valid)
		begin
			busy <= 1'b1;
		end
	end

	// flit layout from msb: dest, source, payload
	always_ff @(posedge clk)
	begin
		if (inject_valid && !busy)
			flit_q <= {inject_dest, NODE_ID_WIDTH'(NODE_ID), inject_data};
	end

	assign inject_busy = busy;
	assign local_valid = busy;
	assign local_flit  = flit_q;

endmodule

// File: hdl/port_fifo.sv
// port input FIFO: buffers incoming link flits and returns a registered full level upstream
`timescale 1ns/1ps

module port_fifo
#(
	parameter int FLIT_WIDTH = 22,
	parameter int FIFO_DEPTH = 4
)
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [FLIT_WIDTH-1:0] wr_flit,
	input  logic                  wr_valid,
	output logic                  full,
	output logic [FLIT_WIDTH-1:0] head_flit,
	output logic                  head_valid,
	input  logic                  pop
);

	localparam int PTR_WIDTH = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	logic [FLIT_WIDTH-1:0]  mem [FIFO_DEPTH];
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic [COUNT_WIDTH-1:0] count_next;
	logic                   do_pop;

	assign head_valid = (count != '0);
	assign head_flit  = mem[rd_ptr];
	assign do_pop     = pop && head_valid;

	// the sender only drives valid while full is low, so no overflow guard here
	assign count_next = count + COUNT_WIDTH'(wr_valid) - COUNT_WIDTH'(do_pop);

	always_ff @(posedge clk)
	begin
		if (wr_valid)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full   <= 1'b0;
		end
		else
		begin
			if (wr_valid)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count_next;
			// full tracks the count that takes effect on this edge
			full  <= (count_next == COUNT_WIDTH'(FIFO_DEPTH));
		end
	end

endmodule

// File: hdl/spidergon_router.sv
// spidergon router: routes fifo heads and the local flit, arbitrates each output round-robin
`timescale 1ns/1ps

module spidergon_router
	import spidergon_pkg::*;
#(
	parameter int NODE_ID = 0,
	parameter int NUM_OF_NODES = 8,
	parameter int FLIT_DATA_WIDTH = 16,
	localparam int NODE_ID_WIDTH = $clog2(NUM_OF_NODES),
	localparam int FLIT_WIDTH = 2 * NODE_ID_WIDTH + FLIT_DATA_WIDTH
)
(
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] head_flit,
	input  logic [NUM_OF_PORTS-1:0]                 head_valid,
	output logic [NUM_OF_PORTS-1:0]                 pop,
	input  logic [FLIT_WIDTH-1:0]                   local_flit,
	input  logic                                    local_valid,
	output logic                                    local_take,
	output logic [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] out_flit,
	output logic [NUM_OF_PORTS-1:0]                 out_valid,
	input  logic [NUM_OF_PORTS-1:0]                 out_full,
	output logic                                    eject_valid,
	output logic [NODE_ID_WIDTH-1:0]                eject_src,
	output logic [FLIT_DATA_WIDTH-1:0]              eject_data
);

	// sources: three fifo heads then the local injector
	localparam int NUM_OF_SOURCES = NUM_OF_PORTS + 1;
	localparam int LOCAL_SRC = NUM_OF_PORTS;
	localparam int SRC_WIDTH = $clog2(NUM_OF_SOURCES);
	// outputs: three links then STOP
	localparam int NUM_OF_OUTPUTS = NUM_OF_PORTS + 1;

	logic [NUM_OF_SOURCES-1:0][FLIT_WIDTH-1:0] src_flit;
	logic [NUM_OF_SOURCES-1:0]                 src_valid;
	port_dir_t                                 src_dir [NUM_OF_SOURCES];
	logic [NUM_OF_OUTPUTS-1:0]                 out_ready;
	logic [SRC_WIDTH-1:0]                      rr_ptr [NUM_OF_OUTPUTS];
	logic [NUM_OF_OUTPUTS-1:0]                 grant_any;
	logic [SRC_WIDTH-1:0]                      grant_src [NUM_OF_OUTPUTS];
	logic [NUM_OF_SOURCES-1:0]                 src_granted;

	assign src_flit  = {local_flit, head_flit};
	assign src_valid = {local_valid, head_valid};

	// ejection never stalls
	assign out_ready = {1'b1, ~out_full};

	always_comb
	begin
		for (int s = 0; s < NUM_OF_SOURCES; s++)
			src_dir[s] = route_dir(NODE_ID, src_flit[s][FLIT_WIDTH-1 -: NODE_ID_WIDTH],
				NUM_OF_NODES);
	end

	// each source wants exactly one output, so grants never collide on a source
	always_comb
	begin
		int cand;
		src_granted = '0;
		for (int o = 0; o < NUM_OF_OUTPUTS; o++)
		begin
			grant_any[o] = 1'b0;
			grant_src[o] = '0;
			// search starts at the pointer and wraps
			for (int i = 0; i < NUM_OF_SOURCES; i++)
			begin
				cand = (int'(rr_ptr[o]) + i) % NUM_OF_SOURCES;
				if (!grant_any[o] && out_ready[o] && src_valid[cand]
					&& src_dir[cand] == port_dir_t'(o))
				begin
					grant_any[o] = 1'b1;
					grant_src[o] = SRC_WIDTH'(cand);
				end
			end
		end
		for (int o = 0; o < NUM_OF_OUTPUTS; o++)
		begin
			if (grant_any[o])
				src_granted[grant_src[o]] = 1'b1;
		end
	end

	// link outputs are a straight mux from the granted source
	always_comb
	begin
		for (int p = 0; p < NUM_OF_PORTS; p++)
		begin
			out_flit[p]  = src_flit[grant_src[p]];
			out_valid[p] = grant_any[p];
		end
	end

	assign pop        = src_granted[NUM_OF_PORTS-1:0];
	assign local_take = src_granted[LOCAL_SRC];

	// winner gets lowest priority next time
	always_ff @(posedge clk)
	begin
		for (int o = 0; o < NUM_OF_OUTPUTS; o++)
		begin
			if (reset)
				rr_ptr[o] <= '0;
			else if (grant_any[o])
				rr_ptr[o] <= (grant_src[o] == SRC_WIDTH'(NUM_OF_SOURCES - 1)) ?
					'0 : grant_src[o] + 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			eject_valid <= 1'b0;
		else
			eject_valid <= grant_any[STOP];
	end

	always_ff @(posedge clk)
	begin
		if (grant_any[STOP])
		begin
			eject_src  <= src_flit[grant_src[STOP]][FLIT_DATA_WIDTH +: NODE_ID_WIDTH];
			eject_data <= src_flit[grant_src[STOP]][FLIT_DATA_WIDTH-1:0];
		end
	end

endmodule

// File: hdl/spidergon_node.sv
// spidergon node: local injector, one input FIFO per link port and the router
`timescale 1ns/1ps

module spidergon_node
	import spidergon_pkg::*;
#(
	parameter int NODE_ID = 0,
	parameter int NUM_OF_NODES = 8,
	parameter int FLIT_DATA_WIDTH = 16,
	parameter int FIFO_DEPTH = 4,
	localparam int NODE_ID_WIDTH = $clog2(NUM_OF_NODES),
	localparam int FLIT_WIDTH = 2 * NODE_ID_WIDTH + FLIT_DATA_WIDTH
)
(
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic                                    inject_valid,
	input  logic [NODE_ID_WIDTH-1:0]                inject_dest,
	input  logic [FLIT_DATA_WIDTH-1:0]              inject_data,
	output logic                                    inject_busy,
	output logic                                    eject_valid,
	output logic [NODE_ID_WIDTH-1:0]                eject_src,
	output logic [FLIT_DATA_WIDTH-1:0]              eject_data,
	input  logic [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] in_flit,
	input  logic [NUM_OF_PORTS-1:0]                 in_valid,
	output logic [NUM_OF_PORTS-1:0]                 in_full,
	output logic [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] out_flit,
	output logic [NUM_OF_PORTS-1:0]                 out_valid,
	input  logic [NUM_OF_PORTS-1:0]                 out_full
);

	logic [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] head_flit;
	logic [NUM_OF_PORTS-1:0]                 head_valid;
	logic [NUM_OF_PORTS-1:0]                 pop;
	logic [FLIT_WIDTH-1:0]                   local_flit;
	logic                                    local_valid;
	logic                                    local_take;

	// the node id enters the flit here as its source field
	flit_injector #(
		.NODE_ID        (NODE_ID),
		.NUM_OF_NODES   (NUM_OF_NODES),
		.FLIT_DATA_WIDTH(FLIT_DATA_WIDTH)
	) u_injector (
		.clk         (clk),
		.reset       (reset),
		.inject_valid(inject_valid),
		.inject_dest (inject_dest),
		.inject_data (inject_data),
		.inject_busy (inject_busy),
		.local_flit  (local_flit),
		.local_valid (local_valid),
		.local_take  (local_take)
	);

	// one buffer per incoming link, indexed by the port it arrives on
	for (genvar p = int'(ANTI_CLOCKWISE); p <= int'(ACROSS); p++)
	begin : g_port
		port_fifo #(
			.FLIT_WIDTH(FLIT_WIDTH),
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk       (clk),
			.reset     (reset),
			.wr_flit   (in_flit[p]),
			.wr_valid  (in_valid[p]),
			.full      (in_full[p]),
			.head_flit (head_flit[p]),
			.head_valid(head_valid[p]),
			.pop       (pop[p])
		);
	end

	spidergon_router #(
		.NODE_ID        (NODE_ID),
		.NUM_OF_NODES   (NUM_OF_NODES),
		.FLIT_DATA_WIDTH(FLIT_DATA_WIDTH)
	) u_router (
		.clk        (clk),
		.reset      (reset),
		.head_flit  (head_flit),
		.head_valid (head_valid),
		.pop        (pop),
		.local_flit (local_flit),
		.local_valid(local_valid),
		.local_take (local_take),
		.out_flit   (out_flit),
		.out_valid  (out_valid),
		.out_full   (out_full),
		.eject_valid(eject_valid),
		.eject_src  (eject_src),
		.eject_data (eject_data)
	);

endmodule

// File: hdl/spidergon_top.sv
// spidergon network top: builds the ring of nodes and the clockwise, anticlockwise and across links
`timescale 1ns/1ps

module spidergon_top
	import spidergon_pkg::*;
#(
	parameter int NUM_OF_NODES = 8,
	parameter int FLIT_DATA_WIDTH = 16,
	parameter int FIFO_DEPTH = 4,
	localparam int NODE_ID_WIDTH = $clog2(NUM_OF_NODES),
	localparam int FLIT_WIDTH = 2 * NODE_ID_WIDTH + FLIT_DATA_WIDTH
)
(
	input  logic                                    clk,
	input  logic                                    reset,
	input  logic [NUM_OF_NODES-1:0]                 inject_valid,
	input  logic [NUM_OF_NODES*NODE_ID_WIDTH-1:0]   inject_dest,
	input  logic [NUM_OF_NODES*FLIT_DATA_WIDTH-1:0] inject_data,
	output logic [NUM_OF_NODES-1:0]                 inject_busy,
	output logic [NUM_OF_NODES-1:0]                 eject_valid,
	output logic [NUM_OF_NODES*NODE_ID_WIDTH-1:0]   eject_src,
	output logic [NUM_OF_NODES*FLIT_DATA_WIDTH-1:0] eject_data
);

	wire [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] node_in_flit   [NUM_OF_NODES];
	wire [NUM_OF_PORTS-1:0]                 node_in_valid  [NUM_OF_NODES];
	wire [NUM_OF_PORTS-1:0]                 node_in_full   [NUM_OF_NODES];
	wire [NUM_OF_PORTS-1:0][FLIT_WIDTH-1:0] node_out_flit  [NUM_OF_NODES];
	wire [NUM_OF_PORTS-1:0]                 node_out_valid [NUM_OF_NODES];
	wire [NUM_OF_PORTS-1:0]                 node_out_full  [NUM_OF_NODES];

	// across links pair node n with n + N/2
	if (NUM_OF_NODES % 2 != 0)
		$error("spidergon needs an even node count");

	for (genvar n = 0; n < NUM_OF_NODES; n++)
	begin : g_node
		localparam int NEXT = (n + 1) % NUM_OF_NODES;
		localparam int PREV = (n + NUM_OF_NODES - 1) % NUM_OF_NODES;
		localparam int OPPOSITE = (n + NUM_OF_NODES / 2) % NUM_OF_NODES;

		// forward: flit and valid from the neighbour's matching output
		assign node_in_flit[n][ANTI_CLOCKWISE]  = node_out_flit[PREV][CLOCKWISE];
		assign node_in_valid[n][ANTI_CLOCKWISE] = node_out_valid[PREV][CLOCKWISE];
		assign node_in_flit[n][CLOCKWISE]       = node_out_flit[NEXT][ANTI_CLOCKWISE];
		assign node_in_valid[n][CLOCKWISE]      = node_out_valid[NEXT][ANTI_CLOCKWISE];
		assign node_in_flit[n][ACROSS]          = node_out_flit[OPPOSITE][ACROSS];
		assign node_in_valid[n][ACROSS]         = node_out_valid[OPPOSITE][ACROSS];

		// backward: full level from the fifo this output writes into
		assign node_out_full[n][CLOCKWISE]      = node_in_full[NEXT][ANTI_CLOCKWISE];
		assign node_out_full[n][ANTI_CLOCKWISE] = node_in_full[PREV][CLOCKWISE];
		assign node_out_full[n][ACROSS]         = node_in_full[OPPOSITE][ACROSS];

		spidergon_node #(
			.NODE_ID        (n),
			.NUM_OF_NODES   (NUM_OF_NODES),
			.FLIT_DATA_WIDTH(FLIT_DATA_WIDTH),
			.FIFO_DEPTH     (FIFO_DEPTH)
		) u_node (
			.clk         (clk),
			.reset       (reset),
			.inject_valid(inject_valid[n]),
			.inject_dest (inject_dest[n*NODE_ID_WIDTH +: NODE_ID_WIDTH]),
			.inject_data (inject_data[n*FLIT_DATA_WIDTH +: FLIT_DATA_WIDTH]),
			.inject_busy (inject_busy[n]),
			.eject_valid (eject_valid[n]),
			.eject_src   (eject_src[n*NODE_ID_WIDTH +: NODE_ID_WIDTH]),
			.eject_data  (eject_data[n*FLIT_DATA_WIDTH +: FLIT_DATA_WIDTH]),
			.in_flit     (node_in_flit[n]),
			.in_valid    (node_in_valid[n]),
			.in_full     (node_in_full[n]),
			.out_flit    (node_out_flit[n]),
			.out_valid   (node_out_valid[n]),
			.out_full    (node_out_full[n])
		);
	end

endmodule

// File: tb/spidergon_props.sv
// router protocol checks: link flow control, fifo pop legality and eject level after reset
`timescale 1ns/1ps

module spidergon_props
	import spidergon_pkg::*;
(
	input logic                    clk,
	input logic                    reset,
	input logic [NUM_OF_PORTS-1:0] out_valid,
	input logic [NUM_OF_PORTS-1:0] out_full,
	input logic [NUM_OF_PORTS-1:0] pop,
	input logic [NUM_OF_PORTS-1:0] head_valid,
	input logic                    eject_valid
);

	int error_count = 0;

	// a link may only carry a flit while the receiving fifo has room
	a_no_send_when_full: assert property (@(posedge clk) disable iff (reset)
		(out_valid & out_full) == '0)
	else
	begin
		$error("link valid while downstream fifo full");
		error_count++;
	end

	// only a non-empty fifo is popped
	a_no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		(pop & ~head_valid) == '0)
	else
	begin
		$error("fifo popped while empty");
		error_count++;
	end

	a_eject_idle_after_reset: assert property (@(posedge clk) reset |=> !eject_valid)
	else
	begin
		$error("eject valid in the cycle after reset");
		error_count++;
	end

endmodule

bind spidergon_router spidergon_props u_props
(
	.clk        (clk),
	.reset      (reset),
	.out_valid  (out_valid),
	.out_full   (out_full),
	.pop        (pop),
	.head_valid (head_valid),
	.eject_valid(eject_valid)
);

// File: tb/spidergon_tb.sv
// spidergon network testbench with random single-flit traffic checked against a per-pair queue model
`timescale 1ns/1ps

module spidergon_tb;

	localparam int NUM_OF_NODES = 8;
	localparam int FLIT_DATA_WIDTH = 16;
	localparam int FIFO_DEPTH = 4;
	localparam int NODE_ID_WIDTH = $clog2(NUM_OF_NODES);
	localparam int STIM_CYCLES = 3000;
	localparam int DRAIN_TIMEOUT = 500;
	localparam int QUIET_CYCLES = 20;

	logic                                    clk;
	logic                                    reset;
	logic [NUM_OF_NODES-1:0]                 inject_valid;
	logic [NUM_OF_NODES*NODE_ID_WIDTH-1:0]   inject_dest;
	logic [NUM_OF_NODES*FLIT_DATA_WIDTH-1:0] inject_data;
	logic [NUM_OF_NODES-1:0]                 inject_busy;
	logic [NUM_OF_NODES-1:0]                 eject_valid;
	logic [NUM_OF_NODES*NODE_ID_WIDTH-1:0]   eject_src;
	logic [NUM_OF_NODES*FLIT_DATA_WIDTH-1:0] eject_data;

	// expected payloads per source and destination pair in injection order
	logic [FLIT_DATA_WIDTH-1:0] exp_q [NUM_OF_NODES][NUM_OF_NODES][$];
	integer                     seed;
	int                         outstanding;
	int                         delivered;
	int                         dropped;
	// self, clockwise, anticlockwise, across
	int                         route_count [4];
	logic [FLIT_DATA_WIDTH-1:0] seq;
	wire [31:0]                 prop_errors [NUM_OF_NODES];

	spidergon_top #(
		.NUM_OF_NODES   (NUM_OF_NODES),
		.FLIT_DATA_WIDTH(FLIT_DATA_WIDTH),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) DUT (
		.clk         (clk),
		.reset       (reset),
		.inject_valid(inject_valid),
		.inject_dest (inject_dest),
		.inject_data (inject_data),
		.inject_busy (inject_busy),
		.eject_valid (eject_valid),
		.eject_src   (eject_src),
		.eject_data  (eject_data)
	);

	// failure counts of the bound router checks
	for (genvar n = 0; n < NUM_OF_NODES; n++)
	begin : g_props
		assign prop_errors[n] = DUT.g_node[n].u_node.u_router.u_props.error_count;
	end

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// class of a route by clockwise distance on the ring
	function automatic int direction_class(input int src, input int dest);
		int rel;
		rel = (dest - src + NUM_OF_NODES) % NUM_OF_NODES;
		if (rel == 0)
			return 0;
		if (rel <= NUM_OF_NODES / 4)
			return 1;
		if (rel >= NUM_OF_NODES - NUM_OF_NODES / 4)
			return 2;
		return 3;
	endfunction

	task automatic check_router_props();
		int total;
		total = 0;
		for (int n = 0; n < NUM_OF_NODES; n++)
			total += int'(prop_errors[n]);
		assert (total == 0)
		else
			report_failure($sformatf("%0d router protocol assertions failed", total));
	endtask

	task automatic check_ejections();
		int                         src;
		logic [FLIT_DATA_WIDTH-1:0] actual;
		logic [FLIT_DATA_WIDTH-1:0] expected;
		for (int d = 0; d < NUM_OF_NODES; d++)
		begin
			if (eject_valid[d])
			begin
				src = int'(eject_src[d*NODE_ID_WIDTH +: NODE_ID_WIDTH]);
				actual = eject_data[d*FLIT_DATA_WIDTH +: FLIT_DATA_WIDTH];
				assert (exp_q[src][d].size() > 0)
				else
					report_failure($sformatf("packet from node %0d ejected at node %0d, data %h, %s",
						src, d, actual, "was never sent there"));
				expected = exp_q[src][d].pop_front();
				assert (actual == expected)
				else
					report_failure($sformatf("Error: delivery %0d->%0d expected %h actual %h",
						src, d, expected, actual));
				outstanding--;
				delivered++;
			end
		end
	endtask

	// new requests only while the network holds fewer than FIFO_DEPTH packets
	task automatic drive_injections(input bit enable);
		logic [31:0]              r;
		logic [NODE_ID_WIDTH-1:0] dest;
		for (int n = 0; n < NUM_OF_NODES; n++)
		begin
			inject_valid[n] = 1'b0;
			r = $random(seed);
			dest = r[2 +: NODE_ID_WIDTH];
			if (enable && r[1:0] == 2'd0 && (inject_busy[n] || outstanding < FIFO_DEPTH))
			begin
				inject_valid[n] = 1'b1;
				inject_dest[n*NODE_ID_WIDTH +: NODE_ID_WIDTH] = dest;
				inject_data[n*FLIT_DATA_WIDTH +: FLIT_DATA_WIDTH] = seq;
				// strobes while busy are lost in the injector
				if (inject_busy[n])
				begin
					dropped++;
				end
				else
				begin
					exp_q[n][dest].push_back(seq);
					outstanding++;
					route_count[direction_class(n, int'(dest))]++;
				end
				seq++;
			end
		end
	endtask

	initial
	begin
		int cycles;
		seed = 32'h29bba8af;
		reset = 1'b1;
		inject_valid = '0;
		inject_dest = '0;
		inject_data = '0;
		outstanding = 0;
		delivered = 0;
		dropped = 0;
		seq = '0;
		for (int c = 0; c < 4; c++)
			route_count[c] = 0;

		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (inject_busy == '0 && eject_valid == '0)
		else
			report_failure($sformatf("Error: reset expected busy %h eject %h actual %h %h",
				'0, '0, inject_busy, eject_valid));
		check_router_props();

		repeat (STIM_CYCLES)
		begin
			@(negedge clk);
			check_router_props();
			check_ejections();
			drive_injections(1'b1);
		end

		cycles = 0;
		while (outstanding != 0 && cycles < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			check_router_props();
			check_ejections();
			drive_injections(1'b0);
			cycles++;
		end
		if (outstanding != 0)
			report_failure($sformatf("network did not drain, %0d packets still in flight",
				outstanding));

		// a late or duplicated packet would show up here
		repeat (QUIET_CYCLES)
		begin
			@(negedge clk);
			check_router_props();
			check_ejections();
		end
		assert (inject_busy == '0)
		else
			report_failure($sformatf("Error: idle busy expected %h actual %h", '0, inject_busy));

		for (int c = 0; c < 4; c++)
		begin
			assert (route_count[c] > 0)
			else
				report_failure($sformatf("route class %0d was never exercised", c));
		end
		assert (dropped > 0)
		else
			report_failure("no strobe was given while an injector was busy");

		$display("%0d packets delivered, %0d strobes dropped", delivered, dropped);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: vlog.f
hdl/spidergon_pkg.sv
hdl/flit_injector.sv
hdl/port_fifo.sv
hdl/spidergon_router.sv
hdl/spidergon_node.sv
hdl/spidergon_top.sv
tb/spidergon_props.sv
tb/spidergon_tb.sv
